// File: build.f
verilog/bus_pkg.sv
verilog/ctrl_pkg.sv
verilog/wb_slave_decode.sv
verilog/settings_bus.sv
verilog/setting_reg.sv
verilog/ctrl_regs.sv
verilog/simple_pic.sv
verilog/status_readback.sv
verilog/u2_ctrl_top.sv
tb/tb_u2_ctrl.sv

// File: Makefile
# Verilator build and run of the control plane testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
TOP       = tb_u2_ctrl
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_u2_ctrl.sv
// Testbench for the control plane top level
// Drives the Wishbone port and board inputs; assertions check the DUT responses

module tb_u2_ctrl import bus_pkg::*, ctrl_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int          CLK_PERIOD   = 40;
   localparam int          DRIVE_DELAY  = 5;
   localparam int          RESET_CYCLES = 16;
   localparam int          ACK_LIMIT    = 16;
   localparam int          UPTIME_GAP   = 20;
   localparam logic [31:0] LFSR_SEED    = 32'h5204_71a5;
   localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

   // External lines used by the interrupt test
   localparam int EDGE_EXT   = 3;
   localparam int MASKED_EXT = 10;

   // Cycle budget per test, summed for the watchdog
   localparam int WATCHDOG_CYC = RESET_CYCLES + 10 + 60 + 80 + 20 + 140 + 60 + 200;

   localparam logic [WB_AW-1:0] STATUS_BASE   = {SLV_STATUS, 12'h000};
   localparam logic [WB_AW-1:0] SETTINGS_BASE = {SLV_SETTINGS, 12'h000};
   localparam logic [WB_AW-1:0] PIC_BASE      = {SLV_PIC, 12'h000};

   logic                         dsp_clk;
   logic                         rst_n;
   logic                         wb_cyc;
   logic                         wb_stb;
   logic                         wb_we;
   logic [WB_AW-1:0]             wb_adr;
   logic [WB_SW-1:0]             wb_sel;
   logic [WB_DW-1:0]             wb_dat_w;
   logic [WB_DW-1:0]             wb_dat_r;
   logic                         wb_ack;
   logic                         wb_err;
   logic                         adr_mapped;
   logic                         sim_mode;
   logic [3:0]                   clock_divider;
   logic                         clk_status;
   logic                         link_up;
   logic [N_IRQ-3:0]             ext_irq;
   logic [$bits(clk_ctrl_t)-1:0] clk_ctrl;
   logic [$bits(ser_ctrl_t)-1:0] ser_ctrl;
   logic [$bits(adc_ctrl_t)-1:0] adc_ctrl;
   logic                         phy_reset_n;
   led_t                         leds;
   logic                         cpu_int;

   // Expected control outputs
   logic [4:0]  exp_clk;
   logic [3:0]  exp_ser;
   logic [3:0]  exp_adc;
   logic        exp_phy_n;

   logic [31:0] lfsr_state;
   int          error_count;
   int          check_count;
   int          test_count;
   int          failed_tests;
   int          test_err_start;

   u2_ctrl_top i_u2_ctrl_top (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n),
      .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
      .wb_sel_i(wb_sel), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
      .wb_err_o(wb_err), .sim_mode_i(sim_mode), .clock_divider_i(clock_divider),
      .clk_status_i(clk_status), .link_up_i(link_up), .ext_irq_i(ext_irq),
      .clk_ctrl_o(clk_ctrl), .ser_ctrl_o(ser_ctrl), .adc_ctrl_o(adc_ctrl),
      .phy_reset_n_o(phy_reset_n), .leds_o(leds), .int_o(cpu_int));

   initial begin
      dsp_clk = 1'b0;
      forever #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
   end

   //////////////////////////////////////////////////
   // Bus protocol checks

   assign adr_mapped = wb_adr[WB_AW-1 -: 4] inside {SLV_STATUS, SLV_SETTINGS, SLV_PIC};

   a_ack_pulse: assert property (@(posedge dsp_clk) disable iff (!rst_n)
      wb_ack |=> !wb_ack)
      else begin
         $display("ack stayed high for two cycles at %0t", $time);
         error_count++;
      end

   a_err_pulse: assert property (@(posedge dsp_clk) disable iff (!rst_n)
      wb_err |=> !wb_err)
      else begin
         $display("err stayed high for two cycles at %0t", $time);
         error_count++;
      end

   // Nothing behind an unmapped address may ack
   a_unmapped_no_ack: assert property (@(posedge dsp_clk) disable iff (!rst_n)
      (wb_cyc && wb_stb && !adr_mapped) |=> !wb_ack)
      else begin
         $display("unmapped address 0x%h was acked at %0t", wb_adr, $time);
         error_count++;
      end

   //////////////////////////////////////////////////
   // Helpers

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic logic [WB_AW-1:0] set_adr(input logic [SET_AW-1:0] sr);
      return SETTINGS_BASE | {6'b0, sr, 2'b00};
   endfunction

   function automatic logic [WB_AW-1:0] pic_adr(input logic [1:0] idx);
      return PIC_BASE | {12'b0, idx, 2'b00};
   endfunction

   function automatic logic [WB_AW-1:0] st_adr(input logic [1:0] idx);
      return STATUS_BASE | {12'b0, idx, 2'b00};
   endfunction

   // Vector slot of an external line, the named sources take two slots
   function automatic int irq_pos(input int ext_idx);
      int pos;
      pos = ext_idx;
      if (pos >= IRQ_LINK_UP)
         pos++;
      if (pos >= IRQ_CLK_STATUS)
         pos++;
      return pos;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count++;
      a_value: assert (got === exp)
         else begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
         end
   endtask

   task automatic check_true(input logic cond, input string what);
      check_count++;
      a_cond: assert (cond === 1'b1)
         else begin
            $display("%s", what);
            error_count++;
         end
   endtask

   task automatic next_cycle();
      @(posedge dsp_clk);
      #DRIVE_DELAY;
   endtask

   // Returns in the cycle where ack or err is seen
   task automatic bus_access(input logic we, input logic [WB_AW-1:0] adr,
                             input logic [WB_DW-1:0] wdata, output logic [WB_DW-1:0] rdata,
                             output logic acked, output logic erred);
      int cycles;
      cycles = 0;
      while (wb_ack || wb_err)
         next_cycle();
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_sel   = '1;
      wb_dat_w = wdata;
      do begin
         next_cycle();
         cycles++;
      end while (!wb_ack && !wb_err && cycles < ACK_LIMIT);
      rdata  = wb_dat_r;
      acked  = wb_ack;
      erred  = wb_err;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      check_true(acked || erred,
                 $sformatf("access to 0x%h got neither ack nor err", adr));
      check_true(!(acked || erred) || cycles == 1,
                 $sformatf("access to 0x%h took %0d cycles instead of one", adr, cycles));
   endtask

   task automatic write_reg(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] d);
      logic [WB_DW-1:0] rd;
      logic             ack;
      logic             err;
      bus_access(1'b1, adr, d, rd, ack, err);
      check_true(ack && !err, $sformatf("write to 0x%h was not acked", adr));
   endtask

   task automatic read_reg(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] rd);
      logic ack;
      logic err;
      bus_access(1'b0, adr, '0, rd, ack, err);
      check_true(ack && !err, $sformatf("read of 0x%h was not acked", adr));
   endtask

   task automatic check_controls();
      check_value("clk_ctrl_o", clk_ctrl, exp_clk);
      check_value("ser_ctrl_o", ser_ctrl, exp_ser);
      check_value("adc_ctrl_o", adc_ctrl, exp_adc);
      check_value("phy_reset_n_o", phy_reset_n, exp_phy_n);
   endtask

   // Outputs hold in the ack cycle and take the new value one cycle later
   task automatic write_setting(input logic [SET_AW-1:0] sr, input logic [31:0] d);
      write_reg(set_adr(sr), d);
      check_controls();
      case (sr)
         SR_CLK:  exp_clk = d[4:0];
         SR_SER:  exp_ser = d[3:0];
         SR_ADC:  exp_adc = d[3:0];
         SR_PHY:  exp_phy_n = ~d[0];
         default: ;
      endcase
      next_cycle();
      check_controls();
   endtask

   task automatic wait_int(input logic level, input int limit, output int cycles);
      cycles = 0;
      while (cpu_int !== level && cycles < limit) begin
         next_cycle();
         cycles++;
      end
      check_true(cpu_int === level,
                 $sformatf("int_o did not go to %b within %0d cycles", level, limit));
   endtask

   task automatic end_test(input string name);
      test_count++;
      if (error_count == test_err_start) begin
         $display("test %0d %s: passed", test_count, name);
      end else begin
         failed_tests++;
         $display("test %0d %s: %0d failed checks", test_count, name,
                  error_count - test_err_start);
      end
      test_err_start = error_count;
   endtask

   //////////////////////////////////////////////////
   // Tests

   task automatic test_reset_state();
      check_controls();
      check_value("leds_o", leds, 8'h00);
      check_value("int_o", cpu_int, 1'b0);
      check_value("wb_ack_o", wb_ack, 1'b0);
      check_value("wb_err_o", wb_err, 1'b0);
      end_test("reset state");
   endtask

   task automatic test_setting_writes();
      logic [31:0] rd;
      write_setting(SR_CLK, random_bits(32));
      write_setting(SR_SER, random_bits(32));
      write_setting(SR_ADC, random_bits(32));
      write_setting(SR_PHY, random_bits(32));
      // Unused setting addresses
      write_setting(8'h05, random_bits(32));
      write_setting(8'hff, random_bits(32));
      check_value("leds_o", leds, 8'h00);
      read_reg(set_adr(SR_CLK), rd);
      check_value("wb_dat_o", rd, 32'h0);
      end_test("setting writes");
   endtask

   task automatic test_led_merge();
      logic [31:0] r;
      led_t        sw;
      led_t        src;
      led_t        hw;
      led_t        exp;
      for (int n = 0; n < 8; n++) begin
         r          = random_bits(18);
         sw         = r[17:10];
         src        = r[9:2];
         clk_status = r[1];
         link_up    = r[0];
         write_setting(SR_LED, {24'b0, sw});
         write_setting(SR_LED_SRC, {24'b0, src});
         hw    = '0;
         hw[0] = link_up;
         hw[1] = clk_status;
         for (int b = 0; b < 8; b++)
            exp[b] = src[b] ? hw[b] : sw[b];
         check_value("leds_o", leds, exp);
      end
      end_test("led merge");
   endtask

   task automatic test_unmapped();
      logic [31:0] rd;
      logic        ack;
      logic        err;
      bus_access(1'b0, 16'h3000, '0, rd, ack, err);
      check_true(err && !ack, "read of unmapped address 0x3000 did not end with err alone");
      bus_access(1'b1, 16'hf004, random_bits(32), rd, ack, err);
      check_true(err && !ack, "write to unmapped address 0xf004 did not end with err alone");
      check_controls();
      read_reg(st_adr(ST_ID), rd);
      end_test("unmapped access");
   endtask

   task automatic test_pic();
      logic [31:0] rd;
      int          cyc;
      int          edge_bit;
      int          masked_bit;
      edge_bit   = irq_pos(EDGE_EXT);
      masked_bit = irq_pos(MASKED_EXT);
      ext_irq    = '0;
      link_up    = 1'b0;
      clk_status = 1'b0;
      write_reg(pic_adr(PIC_EDGE), 32'd1 << edge_bit);
      write_reg(pic_adr(PIC_MASK), 32'h0);
      write_reg(pic_adr(PIC_PEND), 32'hffff_ffff);
      wait_int(1'b0, 8, cyc);

      // One-cycle pulse on an edge source
      ext_irq[EDGE_EXT] = 1'b1;
      next_cycle();
      ext_irq[EDGE_EXT] = 1'b0;
      wait_int(1'b1, 8, cyc);
      check_true(cyc + 1 == 3,
                 $sformatf("int_o rose %0d cycles after the edge instead of 3", cyc + 1));
      read_reg(pic_adr(PIC_PEND), rd);
      check_value("PIC_PEND", rd, 32'd1 << edge_bit);
      read_reg(pic_adr(PIC_RAW), rd);
      check_value("PIC_RAW", rd, 32'h0);
      write_reg(pic_adr(PIC_PEND), 32'd1 << edge_bit);
      wait_int(1'b0, 4, cyc);
      read_reg(pic_adr(PIC_PEND), rd);
      check_value("PIC_PEND", rd, 32'h0);

      // Level source follows the input
      link_up = 1'b1;
      wait_int(1'b1, 8, cyc);
      read_reg(pic_adr(PIC_PEND), rd);
      check_value("PIC_PEND", rd, 32'd1 << IRQ_LINK_UP);
      read_reg(pic_adr(PIC_RAW), rd);
      check_value("PIC_RAW", rd, 32'd1 << IRQ_LINK_UP);
      link_up = 1'b0;
      wait_int(1'b0, 8, cyc);
      read_reg(pic_adr(PIC_PEND), rd);
      check_value("PIC_PEND", rd, 32'h0);

      // Masked source stays quiet
      write_reg(pic_adr(PIC_MASK), 32'd1 << masked_bit);
      ext_irq[MASKED_EXT] = 1'b1;
      for (int n = 0; n < 6; n++) begin
         next_cycle();
         check_true(cpu_int === 1'b0, "masked source raised int_o");
      end
      read_reg(pic_adr(PIC_PEND), rd);
      check_value("PIC_PEND", rd, 32'd1 << masked_bit);
      ext_irq[MASKED_EXT] = 1'b0;
      repeat (4) next_cycle();
      write_reg(pic_adr(PIC_MASK), 32'h0);
      wait_int(1'b0, 8, cyc);
      end_test("interrupt controller");
   endtask

   task automatic test_status();
      logic [31:0] r;
      logic [31:0] rd;
      logic [31:0] up0;
      logic [31:0] up1;
      r             = random_bits(7);
      sim_mode      = r[6];
      clock_divider = r[5:2];
      clk_status    = r[1];
      link_up       = r[0];
      read_reg(st_adr(ST_ID), rd);
      check_value("wb_dat_o ST_ID", rd, {sim_mode, 27'b0, clock_divider});
      read_reg(st_adr(ST_INPUTS), rd);
      check_value("wb_dat_o ST_INPUTS", rd, {30'b0, clk_status, link_up});
      read_reg(st_adr(2'd3), rd);
      check_value("wb_dat_o unused word", rd, 32'h0);
      read_reg(st_adr(ST_UPTIME), up0);
      repeat (UPTIME_GAP) next_cycle();
      read_reg(st_adr(ST_UPTIME), up1);
      check_true(up1 - up0 >= UPTIME_GAP,
                 $sformatf("uptime moved by %0d over %0d idle cycles", up1 - up0, UPTIME_GAP));
      end_test("status readback");
   endtask

   //////////////////////////////////////////////////
   // Main sequence

   initial begin
      rst_n          = 1'b0;
      wb_cyc         = 1'b0;
      wb_stb         = 1'b0;
      wb_we          = 1'b0;
      wb_adr         = '0;
      wb_sel         = '0;
      wb_dat_w       = '0;
      sim_mode       = 1'b0;
      clock_divider  = '0;
      clk_status     = 1'b0;
      link_up        = 1'b0;
      ext_irq        = '0;
      exp_clk        = '0;
      exp_ser        = '0;
      exp_adc        = '0;
      exp_phy_n      = 1'b1;
      lfsr_state     = LFSR_SEED;
      error_count    = 0;
      check_count    = 0;
      test_count     = 0;
      failed_tests   = 0;
      test_err_start = 0;

      repeat (RESET_CYCLES) @(posedge dsp_clk);
      #DRIVE_DELAY;
      rst_n = 1'b1;

      test_reset_state();
      test_setting_writes();
      test_led_merge();
      test_unmapped();
      test_pic();
      test_status();

      $display("summary: %0d tests run, %0d tests failed, %0d checks, %0d check failures",
               test_count, failed_tests, check_count, error_count);
      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYC);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: verilog/u2_ctrl_top.sv
// Control plane of the motherboard core, one Wishbone slave port on dsp_clk
// Decoder in front of the settings, interrupt and status slaves

module u2_ctrl_top import bus_pkg::*, ctrl_pkg::*; (
   input  logic             dsp_clk,
   input  logic             rst_n_i,
   // Wishbone from the processor data bus
   input  logic             wb_cyc_i,
   input  logic             wb_stb_i,
   input  logic             wb_we_i,
   input  logic [WB_AW-1:0] wb_adr_i,
   input  logic [WB_SW-1:0] wb_sel_i,
   input  logic [WB_DW-1:0] wb_dat_i,
   output logic [WB_DW-1:0] wb_dat_o,
   output logic             wb_ack_o,
   output logic             wb_err_o,
   // Board inputs
   input  logic             sim_mode_i,
   input  logic [3:0]       clock_divider_i,
   input  logic             clk_status_i,
   input  logic             link_up_i,
   input  logic [N_IRQ-3:0] ext_irq_i,
   // Control outputs
   output clk_ctrl_t        clk_ctrl_o,
   output ser_ctrl_t        ser_ctrl_o,
   output adc_ctrl_t        adc_ctrl_o,
   output logic             phy_reset_n_o,
   output led_t             leds_o,
   output logic             int_o
);

   slv_sel_t          slv_cyc;
   logic [WB_DW-1:0]  status_dat;
   logic              status_ack;
   logic [WB_DW-1:0]  pic_dat;
   logic              pic_ack;
   logic              settings_ack;
   logic              set_stb;
   logic [SET_AW-1:0] set_addr;
   logic [SET_DW-1:0] set_data;
   logic [N_IRQ-1:0]  irq_vec;

   // Named sources sit at their slots and external lines fill the rest in order
   always_comb begin
      int unsigned k;
      k = 0;
      irq_vec = '0;
      for (int i = 0; i < N_IRQ; i++) begin
         if (i == IRQ_LINK_UP) begin
            irq_vec[i] = link_up_i;
         end else if (i == IRQ_CLK_STATUS) begin
            irq_vec[i] = clk_status_i;
         end else begin
            irq_vec[i] = ext_irq_i[k];
            k++;
         end
      end
   end

   //////////////////////////////////////////////////
   // Decoder and slaves

   wb_slave_decode i_wb_slave_decode (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i),
      .adr_i(wb_adr_i), .status_dat_i(status_dat), .status_ack_i(status_ack),
      .settings_ack_i(settings_ack), .pic_dat_i(pic_dat), .pic_ack_i(pic_ack),
      .slv_cyc_o(slv_cyc), .dat_o(wb_dat_o), .ack_o(wb_ack_o), .err_o(wb_err_o));

   settings_bus i_settings_bus (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .cyc_i(slv_cyc[SEL_SETTINGS]),
      .stb_i(wb_stb_i), .we_i(wb_we_i), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
      .ack_o(settings_ack), .set_stb_o(set_stb), .set_addr_o(set_addr),
      .set_data_o(set_data));

   ctrl_regs i_ctrl_regs (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb), .set_addr_i(set_addr),
      .set_data_i(set_data), .clk_status_i(clk_status_i), .link_up_i(link_up_i),
      .clk_ctrl_o(clk_ctrl_o), .ser_ctrl_o(ser_ctrl_o), .adc_ctrl_o(adc_ctrl_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o));

   simple_pic i_simple_pic (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .cyc_i(slv_cyc[SEL_PIC]), .stb_i(wb_stb_i),
      .we_i(wb_we_i), .adr_i(wb_adr_i[3:2]), .dat_i(wb_dat_i), .irq_i(irq_vec),
      .dat_o(pic_dat), .ack_o(pic_ack), .int_o(int_o));

   status_readback i_status_readback (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .cyc_i(slv_cyc[SEL_STATUS]), .stb_i(wb_stb_i),
      .adr_i(wb_adr_i[3:2]), .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i),
      .clk_status_i(clk_status_i), .link_up_i(link_up_i), .dat_o(status_dat),
      .ack_o(status_ack));

   // Slaves only take full-word writes
   a_full_word_write: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      (wb_cyc_i && wb_stb_i && wb_we_i) |-> (wb_sel_i == {WB_SW{1'b1}}));

endmodule

// File: verilog/status_readback.sv
// Read-only status slave: board identity, live inputs and uptime
// Uptime counts dsp_clk cycles since reset and wraps

module status_readback import bus_pkg::*, ctrl_pkg::*; (
   input  logic             dsp_clk,
   input  logic             rst_n_i,
   input  logic             cyc_i,
   input  logic             stb_i,
   input  logic [3:2]       adr_i,
   input  logic             sim_mode_i,
   input  logic [3:0]       clock_divider_i,
   input  logic             clk_status_i,
   input  logic             link_up_i,
   output logic [WB_DW-1:0] dat_o,
   output logic             ack_o
);

   logic             access;
   logic [WB_DW-1:0] uptime_q;

   assign access = cyc_i & stb_i & ~ack_o;

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o    <= 1'b0;
         uptime_q <= '0;
      end else begin
         ack_o    <= access;
         uptime_q <= uptime_q + 1'b1;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (access) begin
         case (adr_i)
            ST_ID:     dat_o <= {sim_mode_i, {(WB_DW-5){1'b0}}, clock_divider_i};
            ST_INPUTS: dat_o <= {{(WB_DW-2){1'b0}}, clk_status_i, link_up_i};
            ST_UPTIME: dat_o <= uptime_q;
            default:   dat_o <= '0;
         endcase
      end
   end

endmodule

// File: verilog/simple_pic.sv
// Interrupt controller, 16 sources, with mask, edge select and pending words
// Level sources follow the input; edge sources latch until written with 1

module simple_pic import bus_pkg::*, ctrl_pkg::*; (
   input  logic             dsp_clk,
   input  logic             rst_n_i,
   input  logic             cyc_i,
   input  logic             stb_i,
   input  logic             we_i,
   input  logic [3:2]       adr_i,
   input  logic [WB_DW-1:0] dat_i,
   input  logic [N_IRQ-1:0] irq_i,
   output logic [WB_DW-1:0] dat_o,
   output logic             ack_o,
   output logic             int_o
);

   logic             access;
   logic             wr;
   logic [N_IRQ-1:0] mask_q;
   logic [N_IRQ-1:0] edge_q;
   logic [N_IRQ-1:0] pend_q;
   logic [N_IRQ-1:0] irq_q;
   logic [N_IRQ-1:0] irq_d;
   logic [N_IRQ-1:0] irq_rise;
   logic [N_IRQ-1:0] pend_clr;

   assign access = cyc_i & stb_i & ~ack_o;
   assign wr     = access & we_i;

   assign irq_rise = irq_q & ~irq_d;
   assign pend_clr = (wr && adr_i == PIC_PEND) ? dat_i[N_IRQ-1:0] : '0;

   //////////////////////////////////////////////////
   // Control and pending state

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o  <= 1'b0;
         mask_q <= '0;
         edge_q <= '0;
         pend_q <= '0;
         irq_q  <= '0;
         irq_d  <= '0;
         int_o  <= 1'b0;
      end else begin
         ack_o <= access;
         irq_q <= irq_i;
         irq_d <= irq_q;
         if (wr && adr_i == PIC_MASK)
            mask_q <= dat_i[N_IRQ-1:0];
         if (wr && adr_i == PIC_EDGE)
            edge_q <= dat_i[N_IRQ-1:0];
         // A new edge wins over a clear in the same cycle
         pend_q <= (edge_q & ((pend_q & ~pend_clr) | irq_rise)) | (~edge_q & irq_q);
         int_o  <= |(pend_q & ~mask_q);
      end
   end

   // Readback
   always_ff @(posedge dsp_clk) begin
      if (access) begin
         case (adr_i)
            PIC_MASK: dat_o <= WB_DW'(mask_q);
            PIC_EDGE: dat_o <= WB_DW'(edge_q);
            PIC_PEND: dat_o <= WB_DW'(pend_q);
            default:  dat_o <= WB_DW'(irq_q);
         endcase
      end
   end

   // Fully masked means no interrupt on the next cycle
   a_mask_blocks_int: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      (mask_q == '1) |=> !int_o);

endmodule

// File: verilog/ctrl_regs.sv
// Board control setting registers and the LED merge they steer
// Fed from the settings bus; outputs go straight to pins

module ctrl_regs import ctrl_pkg::*; (
   input  logic              dsp_clk,
   input  logic              rst_n_i,
   input  logic              set_stb_i,
   input  logic [SET_AW-1:0] set_addr_i,
   input  logic [SET_DW-1:0] set_data_i,
   input  logic              clk_status_i,
   input  logic              link_up_i,
   output clk_ctrl_t         clk_ctrl_o,
   output ser_ctrl_t         ser_ctrl_o,
   output adc_ctrl_t         adc_ctrl_o,
   output logic              phy_reset_n_o,
   output led_t              leds_o
);

   logic phy_reset;
   led_t led_sw;
   led_t led_src;
   led_t led_hw;

   //////////////////////////////////////////////////
   // Setting registers

   setting_reg #(.MY_ADDR(SR_CLK), .payload_t(clk_ctrl_t)) i_sr_clk (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(clk_ctrl_o));

   setting_reg #(.MY_ADDR(SR_SER), .payload_t(ser_ctrl_t)) i_sr_ser (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(ser_ctrl_o));

   setting_reg #(.MY_ADDR(SR_ADC), .payload_t(adc_ctrl_t)) i_sr_adc (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(adc_ctrl_o));

   setting_reg #(.MY_ADDR(SR_PHY), .payload_t(logic)) i_sr_phy (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(phy_reset));

   setting_reg #(.MY_ADDR(SR_LED), .payload_t(led_t)) i_sr_led (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(led_sw));

   setting_reg #(.MY_ADDR(SR_LED_SRC), .payload_t(led_t)) i_sr_led_src (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(led_src));

   // Setting holds the reset request, the pin is active low
   assign phy_reset_n_o = ~phy_reset;

   //////////////////////////////////////////////////
   // LEDs

   // Hardware view: link at bit 0, clock status at bit 1
   assign led_hw = led_t'({clk_status_i, link_up_i});

   // Source bit set means hardware drives that LED
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// File: verilog/setting_reg.sv
// One register on the settings bus, loaded when the strobe carries its address
// Payload type sets the width; only the low bits of the setting data are kept

module setting_reg import ctrl_pkg::*; #(
   parameter logic [SET_AW-1:0] MY_ADDR = '0,
   parameter type payload_t = logic
) (
   input  logic              dsp_clk,
   input  logic              rst_n_i,
   input  logic              set_stb_i,
   input  logic [SET_AW-1:0] set_addr_i,
   input  logic [SET_DW-1:0] set_data_i,
   output payload_t          out_o
);

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_o <= '0;
      end else if (set_stb_i && (set_addr_i == MY_ADDR)) begin
         out_o <= payload_t'(set_data_i[$bits(payload_t)-1:0]);
      end
   end

endmodule

// File: verilog/settings_bus.sv
// Wishbone slave that turns bus writes into one-cycle setting strobes
// Setting address comes from byte address bits 9..2

module settings_bus import bus_pkg::*, ctrl_pkg::*; (
   input  logic              dsp_clk,
   input  logic              rst_n_i,
   input  logic              cyc_i,
   input  logic              stb_i,
   input  logic              we_i,
   input  logic [WB_AW-1:0]  adr_i,
   input  logic [WB_DW-1:0]  dat_i,
   output logic              ack_o,
   output logic              set_stb_o,
   output logic [SET_AW-1:0] set_addr_o,
   output logic [SET_DW-1:0] set_data_o
);

   logic access;

   // First cycle of a new access
   assign access = cyc_i & stb_i & ~ack_o;

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o     <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         ack_o     <= access;
         set_stb_o <= access & we_i;
      end
   end

   // Address and data only matter while the strobe is up
   always_ff @(posedge dsp_clk) begin
      if (access && we_i) begin
         set_addr_o <= adr_i[SET_AW+1:2];
         set_data_o <= dat_i;
      end
   end

   // Strobe comes with the ack and is a single pulse
   a_set_stb_pulse: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      set_stb_o |-> ack_o ##1 !set_stb_o);

endmodule

// File: verilog/wb_slave_decode.sv
// Address decoder for the control bus
// Picks a slave from address bits 15..12, muxes its data and ack back, errs when unmapped

module wb_slave_decode import bus_pkg::*; (
   input  logic             dsp_clk,
   input  logic             rst_n_i,
   input  logic             cyc_i,
   input  logic             stb_i,
   input  logic [WB_AW-1:0] adr_i,
   input  logic [WB_DW-1:0] status_dat_i,
   input  logic             status_ack_i,
   input  logic             settings_ack_i,
   input  logic [WB_DW-1:0] pic_dat_i,
   input  logic             pic_ack_i,
   output slv_sel_t         slv_cyc_o,
   output logic [WB_DW-1:0] dat_o,
   output logic             ack_o,
   output logic             err_o
);

   slv_sel_t hit;
   slv_sel_t slv_ack;

   always_comb begin
      hit = '0;
      case (adr_i[WB_AW-1 -: SLV_AW])
         SLV_STATUS:   hit[SEL_STATUS]   = 1'b1;
         SLV_SETTINGS: hit[SEL_SETTINGS] = 1'b1;
         SLV_PIC:      hit[SEL_PIC]      = 1'b1;
         default:      hit = '0;
      endcase
   end

   // Cyc is gated per slave, stb is shared
   assign slv_cyc_o = hit & {$bits(slv_sel_t){cyc_i}};

   assign slv_ack[SEL_STATUS]   = status_ack_i;
   assign slv_ack[SEL_SETTINGS] = settings_ack_i;
   assign slv_ack[SEL_PIC]      = pic_ack_i;

   assign ack_o = |(slv_cyc_o & slv_ack);

   // Settings slave is write only and reads as zero
   always_comb begin
      dat_o = '0;
      if (hit[SEL_STATUS])
         dat_o = status_dat_i;
      if (hit[SEL_PIC])
         dat_o = pic_dat_i;
   end

   // Nobody answers an unmapped address, so err it here
   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_o <= 1'b0;
      end else begin
         err_o <= cyc_i & stb_i & (hit == '0) & ~err_o;
      end
   end

   a_sel_onehot: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      $onehot0(slv_cyc_o));

endmodule

// File: verilog/ctrl_pkg.sv
// Setting addresses, setting payloads, interrupt positions and status words
// Imported by the settings path, the interrupt controller and status readback

package ctrl_pkg;

   // Settings bus
   localparam int SET_AW = 8;
   localparam int SET_DW = 32;

   localparam logic [SET_AW-1:0] SR_CLK     = 8'd0;
   localparam logic [SET_AW-1:0] SR_SER     = 8'd1;
   localparam logic [SET_AW-1:0] SR_ADC     = 8'd2;
   localparam logic [SET_AW-1:0] SR_LED     = 8'd3;
   localparam logic [SET_AW-1:0] SR_PHY     = 8'd4;
   localparam logic [SET_AW-1:0] SR_LED_SRC = 8'd8;

   // Setting payloads, MSB first
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clk_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } ser_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   typedef logic [7:0] led_t;

   // Interrupt sources
   localparam int N_IRQ          = 16;
   localparam int IRQ_LINK_UP    = 10;
   localparam int IRQ_CLK_STATUS = 11;

   // Interrupt controller word indices
   localparam logic [1:0] PIC_MASK = 2'd0;
   localparam logic [1:0] PIC_EDGE = 2'd1;
   localparam logic [1:0] PIC_PEND = 2'd2;
   localparam logic [1:0] PIC_RAW  = 2'd3;

   // Status readback word indices
   localparam logic [1:0] ST_ID     = 2'd0;
   localparam logic [1:0] ST_INPUTS = 2'd1;
   localparam logic [1:0] ST_UPTIME = 2'd2;

endpackage

// File: verilog/bus_pkg.sv
// Wishbone widths and slave address map of the control bus
// Imported by the decoder, the slaves and the top level

package bus_pkg;

   // Bus widths
   localparam int WB_DW = 32;
   localparam int WB_AW = 16;
   localparam int WB_SW = 4;

   // Slave number sits in the top address bits
   localparam int SLV_AW = 4;

   localparam logic [SLV_AW-1:0] SLV_STATUS   = 4'h5;
   localparam logic [SLV_AW-1:0] SLV_SETTINGS = 4'h7;
   localparam logic [SLV_AW-1:0] SLV_PIC      = 4'h8;

   // One-hot slave select
   typedef logic [2:0] slv_sel_t;

   localparam int SEL_STATUS   = 0;
   localparam int SEL_SETTINGS = 1;
   localparam int SEL_PIC      = 2;

endpackage
